//--- design/posit_pkg.sv
// ====================
// Posit multiplier shared types
// Widths, decoded-value structs and FSM states for 16-bit posits, es = 3
// ====================
package posit_pkg;

    localparam int NBITS    = 16;
    localparam int ES       = 3;
    localparam int FRAC_W   = 11;        // Widest fraction, hidden bit excluded
    localparam int FH_W     = FRAC_W + 1;
    localparam int SCALE_W  = 9;
    localparam int PSCALE_W = SCALE_W + 1;
    localparam int MBITS    = 2 * FH_W;  // Full fraction product

    typedef logic [NBITS-1:0]    posit_t;
    typedef logic [SCALE_W-1:0]  scale_t;   // Two's complement
    typedef logic [PSCALE_W-1:0] pscale_t;  // Two's complement
    typedef logic [FRAC_W-1:0]   frac_t;
    typedef logic [MBITS-1:0]    mfrac_t;

    localparam posit_t POSIT_NAR    = 16'h8000;
    localparam posit_t POSIT_MAXPOS = 16'h7FFF;
    localparam posit_t POSIT_MINPOS = 16'h0001;

    // Decoded operand
    typedef struct packed {
        logic   sgn;
        scale_t scale;
        frac_t  fraction;
        logic   inf;
        logic   zero;
    } raw_t;

    // Product before rounding
    typedef struct packed {
        logic    sgn;
        pscale_t scale;
        mfrac_t  fraction;
        logic    inf;
        logic    zero;
    } raw_prod_t;

    typedef struct packed {
        posit_t a;
        posit_t b;
    } op_pair_t;

    typedef enum logic [1:0] {IN_IDLE, IN_ACK, IN_WAIT_LOW} in_state_t;
    typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT_LOW} out_state_t;

endpackage

//--- design/posit_decode.sv
// ====================
// Posit decoder
// Registered split of a posit word into sign, scale and fraction
// ====================
`timescale 1ns/1ps

module posit_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  posit_pkg::posit_t in_word,
    output logic              out_valid,
    output posit_pkg::raw_t   out_raw
);
    import posit_pkg::*;

    posit_t                    mag;
    logic [NBITS-2:0]          body;
    logic [NBITS-2:0]          run_src;
    logic [NBITS-2:0]          tail;
    logic                      regime_bit;
    logic                      found;
    logic [4:0]                run;
    logic signed [SCALE_W-1:0] k;
    raw_t                      raw_d;

    assign mag        = in_word[NBITS-1] ? -in_word : in_word;
    assign body       = mag[NBITS-2:0];
    assign regime_bit = body[NBITS-2];
    assign run_src    = regime_bit ? ~body : body;  // Regime run becomes leading zeros

    // Regime run length
    always_comb
    begin
        run   = '0;
        found = 1'b0;
        for (int i = NBITS - 2; i >= 0; i--)
        begin
            if (!found)
            begin
                if (run_src[i])
                    found = 1'b1;
                else
                    run = run + 5'd1;
            end
        end
    end

    // Drop regime and terminator, bits past the word read as zero
    assign tail = body << (run + 5'd1);
    assign k    = regime_bit ? SCALE_W'(run) - 1'b1 : -SCALE_W'(run);

    always_comb
    begin
        raw_d          = '0;
        raw_d.zero     = (in_word == '0);
        raw_d.inf      = (in_word == POSIT_NAR);
        if (!raw_d.zero && !raw_d.inf)
        begin
            raw_d.sgn      = in_word[NBITS-1];
            raw_d.scale    = {k[SCALE_W-ES-1:0], tail[NBITS-2 -: ES]};  // k * 8 + exp
            raw_d.fraction = tail[NBITS-2-ES -: FRAC_W];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        out_raw <= raw_d;
    end

endmodule

//--- design/posit_mult_raw.sv
// ====================
// Raw posit multiplier
// Four-stage product of two decoded values
// ====================
`timescale 1ns/1ps

module posit_mult_raw (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  posit_pkg::raw_t      a,
    input  posit_pkg::raw_t      b,
    output logic                 done,
    output posit_pkg::raw_prod_t product
);
    import posit_pkg::*;

    localparam raw_t RAW_ZERO = '{sgn: 1'b0, scale: '0, fraction: '0, inf: 1'b0, zero: 1'b1};

    logic      r0_start;
    logic      r1_start;
    logic      r2_start;
    logic      r3_start;
    raw_t      r0_a;
    raw_t      r0_b;
    raw_t      r1_a;
    raw_t      r1_b;
    raw_prod_t r1_product;
    raw_prod_t r2_product;
    raw_prod_t r3_product;

    logic [FH_W-1:0] fh_a;
    logic [FH_W-1:0] fh_b;
    mfrac_t          fmul;
    mfrac_t          fshift;

    // Valid bits along the pipe
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r0_start <= 1'b0;
            r1_start <= 1'b0;
            r2_start <= 1'b0;
            r3_start <= 1'b0;
        end
        else
        begin
            r0_start <= start;
            r1_start <= r0_start;
            r2_start <= r1_start;
            r3_start <= r2_start;
        end
    end

    always_ff @(posedge clk)
    begin
        r0_a       <= a.zero ? RAW_ZERO : a;  // Zero operands carry no payload
        r0_b       <= b.zero ? RAW_ZERO : b;
        r1_a       <= r0_a;
        r1_b       <= r0_b;
        r2_product <= r1_product;
        r3_product <= r2_product;
    end

    // Stage 1 arithmetic
    assign fh_a = {1'b1, r1_a.fraction};  // Hidden bits back
    assign fh_b = {1'b1, r1_b.fraction};
    assign fmul = fh_a * fh_b;

    // Product in [1,4), top bit set means one extra scale step
    assign fshift = fmul[MBITS-1] ? (fmul << 1) : (fmul << 2);

    assign r1_product.scale = {r1_a.scale[SCALE_W-1], r1_a.scale}
                            + {r1_b.scale[SCALE_W-1], r1_b.scale}
                            + PSCALE_W'(fmul[MBITS-1]);
    assign r1_product.fraction = fshift;
    assign r1_product.sgn      = r1_a.sgn ^ r1_b.sgn;
    assign r1_product.inf      = r1_a.inf | r1_b.inf;
    assign r1_product.zero     = r1_a.zero | r1_b.zero;

    assign done             = r3_start;
    assign product.sgn      = r3_product.sgn;
    assign product.scale    = r3_product.scale;
    assign product.fraction = r3_product.fraction;
    assign product.inf      = r3_product.inf;
    assign product.zero     = r3_product.zero & ~r3_product.inf;  // NaR wins over zero

endmodule

//--- design/posit_encode.sv
// ====================
// Posit encoder
// Rounds a raw product to nearest even and packs it, saturating
// ====================
`timescale 1ns/1ps

module posit_encode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  posit_pkg::raw_prod_t prod,
    output logic                 out_valid,
    output posit_pkg::posit_t    out_word
);
    import posit_pkg::*;

    localparam int SEED_W = 48;
    localparam int PAD_W  = SEED_W - 2 - ES - MBITS;

    logic signed [PSCALE_W-1:0] k;
    logic [3:0]                 shamt;
    logic [SEED_W-1:0]          seed;
    logic [SEED_W-1:0]          shifted;
    logic [NBITS-2:0]           mag;
    logic                       guard;
    logic                       sticky;
    posit_t                     rounded;
    logic [NBITS-2:0]           mag_sat;
    posit_t                     word_d;

    assign k = $signed(prod.scale) >>> ES;  // Regime value, floor of scale / 8

    // Regime seed is 10 for k >= 0 and 01 for k < 0, arithmetic shift grows the run
    assign seed    = {~k[PSCALE_W-1], k[PSCALE_W-1], prod.scale[ES-1:0], prod.fraction,
                      {PAD_W{1'b0}}};
    assign shamt   = k[PSCALE_W-1] ? ~k[3:0] : k[3:0];  // -k-1 or k
    assign shifted = $signed(seed) >>> shamt;

    assign mag    = shifted[SEED_W-1 -: NBITS-1];
    assign guard  = shifted[SEED_W-NBITS];
    assign sticky = |shifted[SEED_W-NBITS-1:0];

    // Round to nearest, ties to even
    assign rounded = {1'b0, mag} + posit_t'(guard & (sticky | mag[0]));

    always_comb
    begin
        if (k >= 14)
            mag_sat = POSIT_MAXPOS[NBITS-2:0];
        else if (k <= -15)
            mag_sat = POSIT_MINPOS[NBITS-2:0];  // Never underflow to zero
        else if (rounded[NBITS-1])
            mag_sat = POSIT_MAXPOS[NBITS-2:0];
        else if (rounded == '0)
            mag_sat = POSIT_MINPOS[NBITS-2:0];
        else
            mag_sat = rounded[NBITS-2:0];
    end

    always_comb
    begin
        if (prod.inf)
            word_d = POSIT_NAR;
        else if (prod.zero)
            word_d = '0;
        else if (prod.sgn)
            word_d = -{1'b0, mag_sat};
        else
            word_d = {1'b0, mag_sat};
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        out_word <= word_d;
    end

endmodule

//--- design/result_fifo.sv
// ====================
// Result FIFO
// Holds finished products for the output handshake
// ====================
`timescale 1ns/1ps

module result_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr,
    input  posit_pkg::posit_t wdata,
    input  logic              rd,
    output posit_pkg::posit_t rdata,
    output logic              empty
);
    import posit_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    posit_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_ptr] <= wdata;
    end

    assign rdata = mem[rd_ptr];  // Head word
    assign empty = (count == '0);

endmodule

//--- design/credit_counter.sv
// ====================
// Credit counter
// Tracks accepted but undelivered products
// ====================
`timescale 1ns/1ps

module credit_counter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic issue,
    input  logic pop,
    output logic credit_ok
);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] outstanding;  // Pipeline plus FIFO

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            outstanding <= '0;
        else if (issue && !pop)
            outstanding <= outstanding + 1'b1;
        else if (pop && !issue)
            outstanding <= outstanding - 1'b1;
    end

    assign credit_ok = (outstanding < CNT_W'(FIFO_DEPTH));

endmodule

//--- design/handshake_ctrl.sv
// ====================
// Handshake controller
// Four-phase req/ack FSMs for operand input and result output
// ====================
`timescale 1ns/1ps

module handshake_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic op_req,
    output logic op_ack,
    input  logic credit_ok,
    output logic issue,
    input  logic fifo_empty,
    output logic res_req,
    input  logic res_ack,
    output logic pop
);
    import posit_pkg::*;

    in_state_t  in_state;
    out_state_t out_state;

    // Input side
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            in_state <= IN_IDLE;
        else
        begin
            case (in_state)
                IN_IDLE:
                    if (op_req && credit_ok)
                        in_state <= IN_ACK;
                IN_ACK:
                    in_state <= IN_WAIT_LOW;  // Issue lasts one cycle
                IN_WAIT_LOW:
                    if (!op_req)
                        in_state <= IN_IDLE;
                default:
                    in_state <= IN_IDLE;
            endcase
        end
    end

    assign op_ack = (in_state != IN_IDLE);
    assign issue  = (in_state == IN_ACK);

    // Output side
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_state <= OUT_IDLE;
        else
        begin
            case (out_state)
                OUT_IDLE:
                    if (!fifo_empty)
                        out_state <= OUT_REQ;
                OUT_REQ:
                    if (res_ack)
                        out_state <= OUT_WAIT_LOW;
                OUT_WAIT_LOW:
                    if (!res_ack)
                        out_state <= OUT_IDLE;
                default:
                    out_state <= OUT_IDLE;
            endcase
        end
    end

    assign res_req = (out_state == OUT_REQ);
    assign pop     = (out_state == OUT_REQ) && res_ack;  // Head taken by the sink

endmodule

//--- design/posit_mult_top.sv
// ====================
// Posit multiplier top
// Handshake ports, decode, multiply, encode and result buffering
// ====================
`timescale 1ns/1ps

module posit_mult_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                op_req,
    output logic                op_ack,
    input  posit_pkg::op_pair_t op,
    output logic                res_req,
    input  logic                res_ack,
    output posit_pkg::posit_t   res
);
    import posit_pkg::*;

    logic      issue;
    logic      pop;
    logic      credit_ok;
    logic      fifo_empty;
    logic      dec_valid;
    raw_t      raw_a;
    raw_t      raw_b;
    logic      mult_done;
    raw_prod_t prod;
    logic      enc_valid;
    posit_t    enc_word;

    handshake_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_req     (op_req),
        .op_ack     (op_ack),
        .credit_ok  (credit_ok),
        .issue      (issue),
        .fifo_empty (fifo_empty),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .pop        (pop)
    );

    credit_counter #(.FIFO_DEPTH(FIFO_DEPTH)) u_credit (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .pop       (pop),
        .credit_ok (credit_ok)
    );

    // Both decoders run in lockstep, one valid is enough
    posit_decode u_dec_a (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (issue),
        .in_word   (op.a),
        .out_valid (dec_valid),
        .out_raw   (raw_a)
    );

    posit_decode u_dec_b (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (issue),
        .in_word   (op.b),
        .out_valid (),
        .out_raw   (raw_b)
    );

    posit_mult_raw u_mult (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (dec_valid),
        .a       (raw_a),
        .b       (raw_b),
        .done    (mult_done),
        .product (prod)
    );

    posit_encode u_enc (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mult_done),
        .prod      (prod),
        .out_valid (enc_valid),
        .out_word  (enc_word)
    );

    result_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (enc_valid),
        .wdata  (enc_word),
        .rd     (pop),
        .rdata  (res),
        .empty  (fifo_empty)
    );

endmodule

//--- test/posit_checker.sv
// ====================
// Posit multiplier checker
// Reference model, in-order result compare and back-pressure watch
// ====================
`timescale 1ns/1ps

module posit_checker #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                op_req,
    input  logic                op_ack,
    input  posit_pkg::op_pair_t op,
    input  logic                res_req,
    input  logic                res_ack,
    input  posit_pkg::posit_t   res,
    input  logic                bp_window,
    output int                  checks,
    output int                  errors,
    output int                  pending
);
    import posit_pkg::*;

    typedef struct packed {
        logic        nar;
        logic        zero;
        logic        sgn;
        logic [15:0] scale;  // Signed
        logic [10:0] frac;
    } dec_t;

    op_pair_t issued_q[$];  // Operands in issue order
    op_pair_t head;
    posit_t   expected;
    logic     op_ack_d;
    logic     res_ack_d;
    logic     res_ack_rose;
    logic     bp_window_d;
    int       stall_cycles;

    function automatic dec_t decode_posit(input logic [15:0] p);
        dec_t        d;
        logic [15:0] m;
        logic        r;
        logic [2:0]  ex;
        logic [10:0] fr;
        int          run;
        int          pos;
        d = '0;
        if (p == 16'h0000)
            d.zero = 1'b1;
        else if (p == 16'h8000)
            d.nar = 1'b1;
        else
        begin
            d.sgn = p[15];
            m     = p[15] ? -p : p;
            r     = m[14];
            run   = 0;
            while (run < 15 && m[14-run] == r)
                run++;
            pos = 13 - run;  // First bit after the terminator
            ex  = '0;
            fr  = '0;
            for (int i = 2; i >= 0; i--)
            begin
                if (pos >= 0)
                    ex[i] = m[pos];
                pos--;
            end
            for (int i = 10; i >= 0; i--)
            begin
                if (pos >= 0)
                    fr[i] = m[pos];
                pos--;
            end
            d.scale = 8 * (r ? run - 1 : -run) + ex;
            d.frac  = fr;
        end
        return d;
    endfunction

    // Value is 2^scale * (1 + frac / 2^24), rounded to nearest even
    function automatic posit_t round_posit(input logic sgn, input int scale,
                                           input logic [23:0] frac);
        logic [63:0] str;
        logic [14:0] mag;
        logic [2:0]  eb;
        logic        guard;
        logic        sticky;
        int          k;
        int          pos;
        k = scale >>> 3;
        eb = 3'(scale - 8 * k);
        if (k >= 14)
            mag = 15'h7FFF;
        else if (k < -14)
            mag = 15'h0001;  // Tiny values stay at minpos
        else
        begin
            str = '0;
            pos = 63;
            if (k >= 0)
            begin
                for (int i = 0; i <= k; i++)
                begin
                    str[pos] = 1'b1;
                    pos--;
                end
                pos--;  // Terminating zero
            end
            else
            begin
                pos      = 63 + k;
                str[pos] = 1'b1;
                pos--;
            end
            for (int i = 2; i >= 0; i--)
            begin
                str[pos] = eb[i];
                pos--;
            end
            for (int i = 23; i >= 0; i--)
            begin
                str[pos] = frac[i];
                pos--;
            end
            mag    = str[63:49];
            guard  = str[48];
            sticky = |str[47:0];
            if (guard && (sticky || mag[0]) && mag != 15'h7FFF)
                mag = mag + 1'b1;
        end
        return sgn ? -{1'b0, mag} : {1'b0, mag};
    endfunction

    function automatic posit_t mult_model(input posit_t a, input posit_t b);
        dec_t        da;
        dec_t        db;
        logic [23:0] fp;
        logic [23:0] fr;
        int          sc;
        da = decode_posit(a);
        db = decode_posit(b);
        if (da.nar || db.nar)
            return 16'h8000;
        if (da.zero || db.zero)
            return 16'h0000;
        fp = {1'b1, da.frac} * {1'b1, db.frac};
        sc = $signed(da.scale) + $signed(db.scale);
        if (fp[23])
        begin
            sc = sc + 1;
            fr = {fp[22:0], 1'b0};
        end
        else
            fr = {fp[21:0], 2'b00};
        return round_posit(da.sgn ^ db.sgn, sc, fr);
    endfunction

    // Sampled mid-cycle, away from the drive edge
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            issued_q.delete();
            op_ack_d     = 1'b0;
            res_ack_d    = 1'b0;
            res_ack_rose = 1'b0;
            bp_window_d  = 1'b0;
            stall_cycles = 0;
        end
        else
        begin
            if (op_ack && !op_ack_d)
            begin
                if (issued_q.size() >= FIFO_DEPTH)
                begin
                    $display("op_ack rose with %0d operations outstanding", issued_q.size());
                    errors++;
                end
                issued_q.push_back(op);
            end
            if (bp_window && op_req && !op_ack && issued_q.size() == FIFO_DEPTH)
                stall_cycles++;
            if (!bp_window && bp_window_d)
            begin
                if (stall_cycles == 0)
                begin
                    $display("op_ack was never withheld with the FIFO credit used up");
                    errors++;
                end
                stall_cycles = 0;
            end
            if (res_ack && !res_ack_d)
            begin
                if (issued_q.size() == 0)
                begin
                    $display("Result 0x%h delivered with no operation outstanding", res);
                    errors++;
                end
                else
                begin
                    head     = issued_q.pop_front();
                    expected = mult_model(head.a, head.b);
                    checks++;
                    if (res !== expected)
                    begin
                        $display("Mismatch res: expected 0x%h, actual 0x%h (0x%h * 0x%h)",
                                 expected, res, head.a, head.b);
                        errors++;
                    end
                end
            end
            // res_req drops one cycle after the sink acknowledges
            if (res_ack_rose && res_req)
            begin
                $display("res_req still high one cycle after res_ack rose");
                errors++;
            end
            res_ack_rose = res_ack && !res_ack_d;
            op_ack_d     = op_ack;
            res_ack_d    = res_ack;
            bp_window_d  = bp_window;
        end
        pending = issued_q.size();
    end

endmodule

//--- test/tb_top.sv
// ====================
// Posit multiplier testbench
// Clock, reset, LFSR stimulus and four-phase source and sink
// ====================
`timescale 1ns/1ps

module tb_top;
    import posit_pkg::*;

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 500;  // Cycles per wait

    logic        clk;
    logic        arst_n;
    logic        op_req;
    logic        op_ack;
    op_pair_t    op;
    logic        res_req;
    logic        res_ack;
    posit_t      res;
    logic        sink_hold;
    logic        bp_window;
    logic [31:0] lfsr;
    posit_t      x;
    posit_t      y;
    int          checks;
    int          errors;
    int          pending;
    int          test_num;
    int          checks_at_start;
    int          errors_at_start;

    posit_mult_top #(.FIFO_DEPTH(DEPTH)) DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .op_req  (op_req),
        .op_ack  (op_ack),
        .op      (op),
        .res_req (res_req),
        .res_ack (res_ack),
        .res     (res)
    );

    posit_checker #(.FIFO_DEPTH(DEPTH)) u_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_req    (op_req),
        .op_ack    (op_ack),
        .op        (op),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res       (res),
        .bp_window (bp_window),
        .checks    (checks),
        .errors    (errors),
        .pending   (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic posit_t rand_word();
        posit_t w;
        w = '0;
        for (int i = 0; i < NBITS; i++)
            w = {w[NBITS-2:0], lfsr_step()};
        return w;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Error: %s", what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_op_ack(input logic level);
        int n;
        n = 0;
        while (op_ack !== level && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (op_ack !== level)
            abort_on_timeout(level ? "timed out waiting for op_ack" :
                                     "timed out waiting for op_ack to fall");
    endtask

    task automatic wait_res_req_low();
        int n;
        n = 0;
        while (res_req !== 1'b0 && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (res_req !== 1'b0)
            abort_on_timeout("timed out waiting for res_req to fall");
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pending != 0 && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending != 0)
            abort_on_timeout("timed out waiting for the outstanding results");
    endtask

    // Operands stay put until op_ack falls
    task automatic send_op(input posit_t a, input posit_t b);
        op     = {a, b};
        op_req = 1'b1;
        wait_op_ack(1'b1);
        op_req = 1'b0;
        wait_op_ack(1'b0);
    endtask

    task automatic start_test();
        test_num++;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        wait_drained();
        $display("Test %0d %s: %0d results, %0d errors", test_num, name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    // Result sink
    initial
    begin
        res_ack = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (res_req === 1'b1 && !sink_hold)
            begin
                res_ack = 1'b1;
                wait_res_req_low();
                res_ack = 1'b0;
            end
        end
    end

    initial
    begin
        arst_n    = 1'b0;
        op_req    = 1'b0;
        op        = '0;
        sink_hold = 1'b0;
        bp_window = 1'b0;
        lfsr      = 32'h88dec5c8;
        test_num  = 0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test();
        for (int i = 0; i < 8; i++)
        begin
            x = rand_word();
            send_op(16'h0000, x);
            send_op(x, 16'h0000);
            send_op(16'h8000, x);
            send_op(x, 16'h8000);
        end
        send_op(16'h8000, 16'h0000);
        send_op(16'h0000, 16'h0000);
        end_test("special values");

        start_test();
        for (int i = 0; i < 16; i++)
        begin
            x = rand_word();
            send_op(16'h4000, x);
            send_op(x, 16'hC000);  // Negation
        end
        end_test("sign and identity");

        start_test();
        for (int i = 0; i < 500; i++)
            send_op(rand_word(), rand_word());
        end_test("random pairs");

        start_test();
        send_op(16'h7FFF, 16'h7FFF);
        send_op(16'h7FFF, 16'h8001);
        send_op(16'h7FF0, 16'h7FF0);
        send_op(16'h0001, 16'h0001);
        send_op(16'h0001, 16'hFFFF);
        send_op(16'h0002, 16'h0003);
        for (int i = 0; i < 8; i++)
        begin
            x = rand_word() | 16'h7FC0;
            y = rand_word() | 16'h7FC0;
            if (lfsr_step())
                y = -y;
            send_op(x, y);
        end
        end_test("saturation");

        // Sink stalls while the source offers more than the credit allows
        start_test();
        sink_hold = 1'b1;
        bp_window = 1'b1;
        fork
            begin
                for (int i = 0; i < DEPTH + 4; i++)
                    send_op(rand_word(), rand_word());
            end
            begin
                repeat (80) @(posedge clk);
                #1 sink_hold = 1'b0;
            end
        join
        bp_window = 1'b0;
        end_test("back-pressure and order");

        repeat (4) @(posedge clk);
        $display("Summary: %0d results checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- vlog.f
design/posit_pkg.sv
design/posit_decode.sv
design/posit_mult_raw.sv
design/posit_encode.sv
design/result_fifo.sv
design/credit_counter.sv
design/handshake_ctrl.sv
design/posit_mult_top.sv
test/posit_checker.sv
test/tb_top.sv
